// File: src/udma_settings.svh
// uDMA subsystem settings
// bus widths, APB register offsets and the baud divider floor

`ifndef UDMA_SETTINGS_SVH
`define UDMA_SETTINGS_SVH

// L2 read port
`define UDMA_L2_AWIDTH   32
`define UDMA_L2_DWIDTH   32

// APB slave and channel configuration
`define UDMA_APB_AWIDTH  12
`define UDMA_SIZE_WIDTH  16
`define UDMA_DIV_WIDTH   16
`define UDMA_DIV_MIN     2

// register offsets within the 4KB slave window
`define UDMA_REG_SADDR   12'h000
`define UDMA_REG_SIZE    12'h004
`define UDMA_REG_CFG     12'h008
`define UDMA_REG_DIV     12'h00C
`define UDMA_REG_STATUS  12'h010

`endif

// File: src/udma_pkg.sv
// uDMA subsystem types
// L2 read port structs, channel config, event pair and channel FSM states

`default_nettype none

`include "udma_settings.svh"

package udma_pkg;

    typedef logic [`UDMA_L2_AWIDTH-1:0]  l2_addr_t;
    typedef logic [`UDMA_L2_DWIDTH-1:0]  l2_data_t;
    typedef logic [`UDMA_SIZE_WIDTH-1:0] trans_size_t;
    typedef logic [`UDMA_DIV_WIDTH-1:0]  baud_div_t;
    typedef logic [7:0]                  uart_byte_t;

    // read-only L2 port, request side
    typedef struct packed {
        logic     req;
        l2_addr_t addr;
    } l2_rd_req_t;

    // read-only L2 port, response side
    typedef struct packed {
        logic     gnt;
        logic     rvalid;
        l2_data_t rdata;
    } l2_rd_rsp_t;

    // start is a single-cycle strobe
    typedef struct packed {
        l2_addr_t    saddr;
        trans_size_t size;
        logic        start;
    } tx_cfg_t;

    typedef struct packed {
        logic tx_start;
        logic tx_eot;
    } udma_evt_t;

    typedef enum logic [1:0] {IDLE, REQ, WAIT_DATA, SEND} tx_ch_state_e;

endpackage

`default_nettype wire

// File: src/udma_apb_regs.sv
// uDMA APB register file
// zero-wait APB slave with TX channel and UART configuration,
// transfer start strobe and busy status readback

`timescale 1ns/1ps
`default_nettype none

`include "udma_settings.svh"

module udma_apb_regs (
    input  logic                        sys_clk_i,
    input  logic                        rst_i,
    input  logic [`UDMA_APB_AWIDTH-1:0] paddr_i,
    input  udma_pkg::l2_data_t          pwdata_i,
    input  logic                        pwrite_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    output udma_pkg::l2_data_t          prdata_o,
    output logic                        pslverr_o,
    input  logic                        ch_busy_i,
    input  logic                        uart_busy_i,
    output udma_pkg::tx_cfg_t           tx_cfg_o,
    output udma_pkg::baud_div_t         baud_div_o
);
    import udma_pkg::*;

    logic        access;
    logic        hit;
    logic        wr_en;
    logic        start_req;
    baud_div_t   div_wr;
    l2_addr_t    saddr_q;
    trans_size_t size_q;
    baud_div_t   div_q;
    logic        start_q;

    // access phase of an APB transfer
    assign access = psel_i && penable_i;
    assign wr_en  = access && pwrite_i && hit;

    // address decode and readback mux
    always_comb begin
        hit      = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            `UDMA_REG_SADDR:  prdata_o = saddr_q;
            `UDMA_REG_SIZE:   prdata_o = l2_data_t'(size_q);
            `UDMA_REG_CFG:    prdata_o = '0;
            `UDMA_REG_DIV:    prdata_o = l2_data_t'(div_q);
            `UDMA_REG_STATUS: prdata_o = {30'b0, uart_busy_i, ch_busy_i};
            default:          hit      = 1'b0;
        endcase
    end

    assign pslverr_o = access && !hit;

    // divider below the floor is stored as the floor
    assign div_wr = (pwdata_i[`UDMA_DIV_WIDTH-1:0] < baud_div_t'(`UDMA_DIV_MIN)) ?
                    baud_div_t'(`UDMA_DIV_MIN) : pwdata_i[`UDMA_DIV_WIDTH-1:0];

    // start only accepted on an idle channel with work to do
    assign start_req = wr_en && (paddr_i == `UDMA_REG_CFG) && pwdata_i[0] &&
                       !ch_busy_i && !start_q && (size_q != '0);

    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            saddr_q <= '0;
            size_q  <= '0;
            div_q   <= baud_div_t'(`UDMA_DIV_MIN);
            start_q <= 1'b0;
        end else begin
            start_q <= start_req;
            if (wr_en) begin
                case (paddr_i)
                    `UDMA_REG_SADDR: saddr_q <= pwdata_i;
                    `UDMA_REG_SIZE:  size_q  <= pwdata_i[`UDMA_SIZE_WIDTH-1:0];
                    `UDMA_REG_DIV:   div_q   <= div_wr;
                    default:         ;
                endcase
            end
        end
    end

    assign tx_cfg_o   = '{saddr: saddr_q, size: size_q, start: start_q};
    assign baud_div_o = div_q;

    // strobe lands on an idle channel, which then picks it up
    a_start_idle: assert property (
        @(posedge sys_clk_i) disable iff (rst_i)
        tx_cfg_o.start |-> !ch_busy_i ##1 ch_busy_i
    ) else $error("start strobe not taken by an idle channel");

endmodule

`default_nettype wire

// File: src/udma_tx_channel.sv
// uDMA linear TX channel
// fetches L2 words over the read-only port and feeds their bytes
// to the UART in address order, with start and end-of-transfer events

`timescale 1ns/1ps
`default_nettype none

module udma_tx_channel (
    input  logic                 sys_clk_i,
    input  logic                 rst_i,
    input  udma_pkg::tx_cfg_t    tx_cfg_i,
    output udma_pkg::l2_rd_req_t l2_req_o,
    input  udma_pkg::l2_rd_rsp_t l2_rsp_i,
    input  logic                 uart_busy_i,
    output udma_pkg::uart_byte_t tx_byte_o,
    output logic                 tx_strobe_o,
    output logic                 busy_o,
    output udma_pkg::udma_evt_t  evt_o
);
    import udma_pkg::*;

    tx_ch_state_e state_q;
    l2_addr_t     addr_q;
    trans_size_t  remaining_q;
    l2_data_t     word_q;
    logic         start_evt_q;
    logic         eot_evt_q;
    logic         last_byte;
    logic         lane_wrap;

    assign last_byte = (remaining_q == trans_size_t'(1));
    assign lane_wrap = (addr_q[1:0] == 2'b11);

    // hand a byte over whenever the UART is free
    assign tx_strobe_o = (state_q == SEND) && (remaining_q != '0) && !uart_busy_i;
    // little endian lane select
    assign tx_byte_o   = word_q[{addr_q[1:0], 3'b000} +: 8];

    assign l2_req_o = '{req: (state_q == REQ), addr: {addr_q[31:2], 2'b00}};
    assign busy_o   = (state_q != IDLE);
    assign evt_o    = '{tx_start: start_evt_q, tx_eot: eot_evt_q};

    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            state_q     <= IDLE;
            remaining_q <= '0;
            start_evt_q <= 1'b0;
            eot_evt_q   <= 1'b0;
        end else begin
            start_evt_q <= 1'b0;
            eot_evt_q   <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (tx_cfg_i.start) begin
                        state_q     <= REQ;
                        remaining_q <= tx_cfg_i.size;
                        start_evt_q <= 1'b1;
                    end
                end
                REQ: begin
                    if (l2_rsp_i.gnt) begin
                        state_q <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (l2_rsp_i.rvalid) begin
                        state_q <= SEND;
                    end
                end
                SEND: begin
                    if (remaining_q == '0) begin
                        // last stop bit done
                        if (!uart_busy_i) begin
                            state_q   <= IDLE;
                            eot_evt_q <= 1'b1;
                        end
                    end else if (!uart_busy_i) begin
                        remaining_q <= remaining_q - trans_size_t'(1);
                        if (lane_wrap && !last_byte) begin
                            state_q <= REQ;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // address pointer and fetched word
    always_ff @(posedge sys_clk_i) begin
        if ((state_q == IDLE) && tx_cfg_i.start) begin
            addr_q <= tx_cfg_i.saddr;
        end else if (tx_strobe_o) begin
            addr_q <= addr_q + l2_addr_t'(1);
        end
        if ((state_q == WAIT_DATA) && l2_rsp_i.rvalid) begin
            word_q <= l2_rsp_i.rdata;
        end
    end

    a_req_stable: assert property (
        @(posedge sys_clk_i) disable iff (rst_i)
        l2_req_o.req && !l2_rsp_i.gnt |=> l2_req_o.req && $stable(l2_req_o.addr)
    ) else $error("L2 request dropped or changed before grant");

    a_rvalid_expected: assert property (
        @(posedge sys_clk_i) disable iff (rst_i)
        l2_rsp_i.rvalid |-> (state_q == WAIT_DATA)
    ) else $error("L2 rvalid without an outstanding read");

endmodule

`default_nettype wire

// File: src/udma_baud_timer.sv
// UART baud timer
// one-cycle tick every div clock cycles while the transmitter runs

`timescale 1ns/1ps
`default_nettype none

module udma_baud_timer (
    input  logic                sys_clk_i,
    input  logic                rst_i,
    input  logic                run_i,
    input  udma_pkg::baud_div_t div_i,
    output logic                tick_o
);
    import udma_pkg::*;

    baud_div_t cnt_q;

    // >= keeps the period bounded if div shrinks mid-frame
    assign tick_o = run_i && (cnt_q >= (div_i - baud_div_t'(1)));

    always_ff @(posedge sys_clk_i) begin
        if (rst_i || !run_i) begin
            // idle restart, so every frame opens with a full bit
            cnt_q <= '0;
        end else if (tick_o) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + baud_div_t'(1);
        end
    end

    a_tick_spacing: assert property (
        @(posedge sys_clk_i) disable iff (rst_i)
        tick_o ##1 run_i |-> !tick_o
    ) else $error("baud ticks on consecutive cycles");

endmodule

`default_nettype wire

// File: src/udma_uart_tx.sv
// UART transmitter, 8N1
// loads a byte on the strobe and sends start, 8 data bits LSB first
// and a stop bit, one bit per baud tick

`timescale 1ns/1ps
`default_nettype none

module udma_uart_tx (
    input  logic                 sys_clk_i,
    input  logic                 rst_i,
    input  udma_pkg::uart_byte_t byte_i,
    input  logic                 strobe_i,
    input  logic                 tick_i,
    output logic                 run_o,
    output logic                 busy_o,
    output logic                 uart_tx_o
);
    import udma_pkg::*;

    // data bits followed by the stop bit
    logic [8:0] shreg_q;
    logic [3:0] bit_cnt_q;
    logic       busy_q;
    logic       line_q;
    logic       load;
    logic       shift;

    assign load  = strobe_i && !busy_q;
    assign shift = busy_q && tick_i;

    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            busy_q    <= 1'b0;
            line_q    <= 1'b1;
            bit_cnt_q <= '0;
        end else if (load) begin
            // start bit goes out right away
            busy_q    <= 1'b1;
            line_q    <= 1'b0;
            bit_cnt_q <= '0;
        end else if (shift) begin
            if (bit_cnt_q == 4'd9) begin
                // end of stop bit
                busy_q <= 1'b0;
                line_q <= 1'b1;
            end else begin
                line_q    <= shreg_q[0];
                bit_cnt_q <= bit_cnt_q + 4'd1;
            end
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (load) begin
            shreg_q <= {1'b1, byte_i};
        end else if (shift) begin
            shreg_q <= {1'b1, shreg_q[8:1]};
        end
    end

    assign run_o     = busy_q;
    assign busy_o    = busy_q;
    assign uart_tx_o = line_q;

    // no byte may arrive while a frame is on the line
    a_strobe_idle: assert property (
        @(posedge sys_clk_i) disable iff (rst_i)
        strobe_i |-> !busy_q
    ) else $error("byte strobed while UART busy");

endmodule

`default_nettype wire

// File: src/udma_subsystem.sv
// uDMA subsystem top
// APB register file, linear TX channel, baud timer and UART transmitter

`timescale 1ns/1ps
`default_nettype none

`include "udma_settings.svh"

module udma_subsystem (
    input  logic                        sys_clk_i,
    input  logic                        rst_i,
    input  logic [`UDMA_APB_AWIDTH-1:0] paddr_i,
    input  udma_pkg::l2_data_t          pwdata_i,
    input  logic                        pwrite_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    output udma_pkg::l2_data_t          prdata_o,
    output logic                        pslverr_o,
    output udma_pkg::l2_rd_req_t        l2_req_o,
    input  udma_pkg::l2_rd_rsp_t        l2_rsp_i,
    output logic                        uart_tx_o,
    output udma_pkg::udma_evt_t         events_o
);
    import udma_pkg::*;

    tx_cfg_t    s_tx_cfg;
    baud_div_t  s_baud_div;
    logic       s_ch_busy;
    logic       s_uart_busy;
    uart_byte_t s_tx_byte;
    logic       s_tx_strobe;
    logic       s_baud_run;
    logic       s_baud_tick;

    udma_apb_regs i_udma_apb_regs (
        .sys_clk_i   ( sys_clk_i   ),
        .rst_i       ( rst_i       ),
        .paddr_i     ( paddr_i     ),
        .pwdata_i    ( pwdata_i    ),
        .pwrite_i    ( pwrite_i    ),
        .psel_i      ( psel_i      ),
        .penable_i   ( penable_i   ),
        .prdata_o    ( prdata_o    ),
        .pslverr_o   ( pslverr_o   ),
        .ch_busy_i   ( s_ch_busy   ),
        .uart_busy_i ( s_uart_busy ),
        .tx_cfg_o    ( s_tx_cfg    ),
        .baud_div_o  ( s_baud_div  )
    );

    udma_tx_channel i_udma_tx_channel (
        .sys_clk_i   ( sys_clk_i   ),
        .rst_i       ( rst_i       ),
        .tx_cfg_i    ( s_tx_cfg    ),
        .l2_req_o    ( l2_req_o    ),
        .l2_rsp_i    ( l2_rsp_i    ),
        .uart_busy_i ( s_uart_busy ),
        .tx_byte_o   ( s_tx_byte   ),
        .tx_strobe_o ( s_tx_strobe ),
        .busy_o      ( s_ch_busy   ),
        .evt_o       ( events_o    )
    );

    udma_baud_timer i_udma_baud_timer (
        .sys_clk_i ( sys_clk_i   ),
        .rst_i     ( rst_i       ),
        .run_i     ( s_baud_run  ),
        .div_i     ( s_baud_div  ),
        .tick_o    ( s_baud_tick )
    );

    udma_uart_tx i_udma_uart_tx (
        .sys_clk_i ( sys_clk_i   ),
        .rst_i     ( rst_i       ),
        .byte_i    ( s_tx_byte   ),
        .strobe_i  ( s_tx_strobe ),
        .tick_i    ( s_baud_tick ),
        .run_o     ( s_baud_run  ),
        .busy_o    ( s_uart_busy ),
        .uart_tx_o ( uart_tx_o   )
    );

endmodule

`default_nettype wire

// File: tb/udma_l2_mem_model.sv
// L2 memory model for the read-only port
// random-filled word memory, answers each request with a granted read
// after random grant and rvalid delays of 0 to 3 cycles

`timescale 1ns/1ps
`default_nettype none

module udma_l2_mem_model (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  udma_pkg::l2_rd_req_t req_i,
    output udma_pkg::l2_rd_rsp_t rsp_o
);
    import udma_pkg::*;

    // 1KB window, byte address bits 9:2 pick the word
    logic [31:0] mem [0:255];
    integer      seed;
    logic [31:0] rnd;
    logic        pending_q;
    logic [1:0]  gnt_wait_q;
    logic [1:0]  rv_wait_q;
    l2_addr_t    rd_addr_q;

    initial begin
        integer i;
        seed = 32'h11de_e691;
        for (i = 0; i < 256; i = i + 1) begin
            mem[i] = $random(seed);
        end
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            rsp_o      <= '0;
            pending_q  <= 1'b0;
            gnt_wait_q <= 2'd0;
            rv_wait_q  <= 2'd0;
        end else begin
            rsp_o.gnt    <= 1'b0;
            rsp_o.rvalid <= 1'b0;
            if (!pending_q && req_i.req) begin
                if (gnt_wait_q == 2'd0) begin
                    rsp_o.gnt <= 1'b1;
                    rd_addr_q <= req_i.addr;
                    pending_q <= 1'b1;
                    rnd = $random(seed);
                    rv_wait_q <= rnd[1:0];
                end else begin
                    gnt_wait_q <= gnt_wait_q - 2'd1;
                end
            end else if (pending_q) begin
                if (rv_wait_q == 2'd0) begin
                    rsp_o.rvalid <= 1'b1;
                    rsp_o.rdata  <= mem[rd_addr_q[9:2]];
                    pending_q    <= 1'b0;
                    rnd = $random(seed);
                    gnt_wait_q <= rnd[1:0];
                end else begin
                    rv_wait_q <= rv_wait_q - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_udma_subsystem.sv
// uDMA subsystem testbench
// APB register checks, table driven UART transfers from the L2 model,
// UART frame decoding with bit timing checks, event counting

`timescale 1ns/1ps
`default_nettype none

`include "udma_settings.svh"

module tb_udma_subsystem;
    import udma_pkg::*;

    typedef struct packed {
        logic [31:0] saddr;
        logic [15:0] size;
        logic [15:0] div;
    } row_t;

    localparam int NUM_ROWS = 5;

    row_t rows [0:NUM_ROWS-1] = '{
        '{saddr: 32'h0000_0100, size: 16'd1, div: 16'd2},
        '{saddr: 32'h0000_0203, size: 16'd5, div: 16'd3},
        '{saddr: 32'h0000_0041, size: 16'd9, div: 16'd7},
        '{saddr: 32'h0000_02F9, size: 16'd5, div: 16'd2},
        '{saddr: 32'h0000_0006, size: 16'd9, div: 16'd3}
    };

    logic                        sys_clk_i;
    logic                        rst_i;
    logic [`UDMA_APB_AWIDTH-1:0] paddr_i;
    l2_data_t                    pwdata_i;
    logic                        pwrite_i;
    logic                        psel_i;
    logic                        penable_i;
    l2_data_t                    prdata_o;
    logic                        pslverr_o;
    l2_rd_req_t                  l2_req;
    l2_rd_rsp_t                  l2_rsp;
    logic                        uart_tx_o;
    udma_evt_t                   events_o;

    integer     errors = 0;
    integer     checks = 0;
    integer     start_cnt = 0;
    integer     eot_cnt = 0;
    integer     fall_cnt = 0;
    integer     rx_div = 2;
    integer     cycles = 0;
    logic       prev_line = 1'b1;
    uart_byte_t rx_q [$];

    udma_subsystem i_udma_subsystem (
        .sys_clk_i ( sys_clk_i ),
        .rst_i     ( rst_i     ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .pwrite_i  ( pwrite_i  ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .prdata_o  ( prdata_o  ),
        .pslverr_o ( pslverr_o ),
        .l2_req_o  ( l2_req    ),
        .l2_rsp_i  ( l2_rsp    ),
        .uart_tx_o ( uart_tx_o ),
        .events_o  ( events_o  )
    );

    udma_l2_mem_model i_l2_mem (
        .clk_i ( sys_clk_i ),
        .rst_i ( rst_i     ),
        .req_i ( l2_req    ),
        .rsp_o ( l2_rsp    )
    );

    initial begin
        sys_clk_i = 1'b0;
        forever #4 sys_clk_i = ~sys_clk_i;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks = checks + 1;
        assert (got === exp) else begin
            errors = errors + 1;
            $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks = checks + 1;
        assert (cond === 1'b1) else begin
            errors = errors + 1;
            $display("check failed: %s", what);
        end
    endtask

    // one zero-wait APB transfer, data sampled mid access phase
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge sys_clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge sys_clk_i);
        penable_i <= 1'b1;
        @(negedge sys_clk_i);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge sys_clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, wdata, rd, err);
        compare_value("pslverr_o", {31'b0, err}, 32'h0);
    endtask

    task automatic apb_read_check(input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, addr, 32'h0, rd, err);
        compare_value("pslverr_o", {31'b0, err}, 32'h0);
        compare_value("prdata_o", rd, exp);
    endtask

    // little endian byte of the model memory
    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        logic [31:0] w;
        integer      lane;
        w    = i_l2_mem.mem[a[9:2]];
        lane = a[1:0];
        return 8'(w >> (8 * lane));
    endfunction

    function automatic integer test_cycle_limit();
        integer sum;
        integer i;
        sum = 2000;
        for (i = 0; i < NUM_ROWS; i = i + 1) begin
            sum = sum + (rows[i].size + 1) * 10 * rows[i].div * 2;
        end
        return sum;
    endfunction

    // events and line falls seen at the falling clock edge
    always @(negedge sys_clk_i) begin
        if (!rst_i) begin
            if (events_o.tx_start) start_cnt = start_cnt + 1;
            if (events_o.tx_eot) eot_cnt = eot_cnt + 1;
            if (prev_line && !uart_tx_o) fall_cnt = fall_cnt + 1;
            prev_line = uart_tx_o;
        end
    end

    // 8N1 decoder, every bit must hold for div cycles
    initial begin : uart_decoder
        logic [9:0] bits;
        logic       v;
        integer     b;
        integer     c;
        integer     div;
        forever begin
            @(negedge sys_clk_i);
            if (!rst_i && uart_tx_o === 1'b0) begin
                div = rx_div;
                for (b = 0; b < 10; b = b + 1) begin
                    if (b > 0) @(negedge sys_clk_i);
                    v = uart_tx_o;
                    for (c = 1; c < div; c = c + 1) begin
                        @(negedge sys_clk_i);
                        check_true(uart_tx_o === v, "UART bit changed within its period");
                    end
                    bits[b] = v;
                end
                compare_value("start bit", {31'b0, bits[0]}, 32'h0);
                compare_value("stop bit", {31'b0, bits[9]}, 32'h1);
                rx_q.push_back(bits[8:1]);
            end
        end
    end

    initial begin : timeout
        integer limit;
        limit = test_cycle_limit();
        while (cycles < limit) begin
            @(posedge sys_clk_i);
            cycles = cycles + 1;
        end
        $display("timeout after %0d cycles, transfers did not complete", cycles);
        $display("summary: %0d checks, %0d errors", checks, errors);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : main
        integer r;
        integer k;
        logic [31:0] rd;
        logic        err;
        rst_i     = 1'b1;
        paddr_i   = '0;
        pwdata_i  = '0;
        pwrite_i  = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        repeat (5) @(posedge sys_clk_i);
        rst_i <= 1'b0;
        @(negedge sys_clk_i);
        compare_value("uart_tx_o", {31'b0, uart_tx_o}, 32'h1);
        compare_value("l2_req_o.req", {31'b0, l2_req.req}, 32'h0);
        compare_value("events_o", {30'b0, events_o}, 32'h0);
        compare_value("pslverr_o", {31'b0, pslverr_o}, 32'h0);

        // register readback and divider floor
        apb_write(`UDMA_REG_SADDR, 32'h1234_5679);
        apb_read_check(`UDMA_REG_SADDR, 32'h1234_5679);
        apb_write(`UDMA_REG_SIZE, 32'hABCD_0000);
        apb_read_check(`UDMA_REG_SIZE, 32'h0000_0000);
        apb_write(`UDMA_REG_DIV, 32'h0000_0000);
        apb_read_check(`UDMA_REG_DIV, 32'h0000_0002);
        apb_write(`UDMA_REG_DIV, 32'h0000_0001);
        apb_read_check(`UDMA_REG_DIV, 32'h0000_0002);
        apb_write(`UDMA_REG_DIV, 32'h0000_0007);
        apb_read_check(`UDMA_REG_DIV, 32'h0000_0007);
        apb_read_check(`UDMA_REG_CFG, 32'h0);

        // unmapped offset
        apb_access(1'b1, 12'h014, 32'hFFFF_FFFF, rd, err);
        compare_value("pslverr_o", {31'b0, err}, 32'h1);
        apb_access(1'b0, 12'h014, 32'h0, rd, err);
        compare_value("pslverr_o", {31'b0, err}, 32'h1);
        compare_value("prdata_o", rd, 32'h0);
        apb_read_check(`UDMA_REG_SADDR, 32'h1234_5679);
        apb_read_check(`UDMA_REG_SIZE, 32'h0000_0000);
        apb_read_check(`UDMA_REG_DIV, 32'h0000_0007);

        // a start with SIZE 0 does nothing
        start_cnt = 0;
        eot_cnt   = 0;
        fall_cnt  = 0;
        apb_write(`UDMA_REG_CFG, 32'h1);
        repeat (40) @(posedge sys_clk_i);
        compare_value("tx_start count", start_cnt, 0);
        compare_value("tx_eot count", eot_cnt, 0);
        compare_value("uart_tx_o falls", fall_cnt, 0);

        for (r = 0; r < NUM_ROWS; r = r + 1) begin
            apb_write(`UDMA_REG_SADDR, rows[r].saddr);
            apb_write(`UDMA_REG_SIZE, {16'b0, rows[r].size});
            apb_write(`UDMA_REG_DIV, {16'b0, rows[r].div});
            rx_div = rows[r].div;
            rx_q.delete();
            start_cnt = 0;
            eot_cnt   = 0;
            apb_write(`UDMA_REG_CFG, 32'h1);
            apb_access(1'b0, `UDMA_REG_STATUS, 32'h0, rd, err);
            compare_value("status busy", {31'b0, rd[0]}, 32'h1);
            // start while busy must be dropped
            apb_write(`UDMA_REG_CFG, 32'h1);
            while (eot_cnt == 0) @(negedge sys_clk_i);
            compare_value("bytes before tx_eot", rx_q.size(), rows[r].size);
            apb_access(1'b0, `UDMA_REG_STATUS, 32'h0, rd, err);
            compare_value("status busy", {31'b0, rd[0]}, 32'h0);
            repeat (3 * rows[r].div + 5) @(posedge sys_clk_i);
            compare_value("tx_start count", start_cnt, 1);
            compare_value("tx_eot count", eot_cnt, 1);
            compare_value("decoded byte count", rx_q.size(), rows[r].size);
            for (k = 0; k < rows[r].size && k < rx_q.size(); k = k + 1) begin
                compare_value("uart byte", {24'b0, rx_q[k]},
                              {24'b0, mem_byte(rows[r].saddr + k)});
            end
        end

        repeat (5) @(posedge sys_clk_i);
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+src
src/udma_pkg.sv
src/udma_apb_regs.sv
src/udma_tx_channel.sv
src/udma_baud_timer.sv
src/udma_uart_tx.sv
src/udma_subsystem.sv
tb/udma_l2_mem_model.sv
tb/tb_udma_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the uDMA subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -sv -Wno-fatal \
    -f flist.f --top-module tb_udma_subsystem \
    -o tb_udma_subsystem > build.log 2>&1 \
    && ./obj_dir/tb_udma_subsystem > "$LOG" 2>&1 \
    || { cat build.log "$LOG" 2>/dev/null; echo "build or run error"; exit 1; }

cat "$LOG"

grep -q "Simulation FAILED" "$LOG" && exit 1
grep -q "Simulation PASSED" "$LOG" || exit 1
exit 0
